/* vlog.f */
common/trs_io_pkg.sv
spi/spi_byte_rx.sv
spi/spi_byte_tx.sv
src/cmd_decoder.sv
src/trs_io_regs.sv
src/trs_io_top.sv
verification/trs_io_assertions.sv
verification/tb_trs_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_trs_io -f vlog.f -o sim_trs_io > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
{ ./obj_dir/sim_trs_io > sim.log 2>&1 || echo "simulator exited with an error"; } \
  && cat sim.log \
  && grep -qx "PASS: all tests" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verification/tb_trs_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_trs_io
  import trs_io_pkg::*;
();

  localparam int    PHASE_CLKS  = 8;      // clk cycles per sck phase
  localparam int    WAIT_LIMIT  = 200;    // cycles before a wait gives up
  localparam byte_t EXP_COOKIE  = 8'hAF;
  localparam byte_t EXP_VERSION = {3'd0, 5'd3};  // major 0, minor 3

  logic  clk;
  logic  cass_out_sel_n;
  logic  spi_cs_n;
  logic  sck;
  logic  mosi;
  logic  miso;
  led_t  led;
  byte_t esp_status;
  rgb_t  screen_color;
  logic  key_pressed;
  logic  spi_error;

  // reference model of the register bank
  led_t  exp_led;
  byte_t exp_status;
  rgb_t  exp_color;
  byte_t exp_matrix [KEYB_ROWS];
  logic  exp_error;

  int err_count;
  int timeout_count;
  int check_count;

  trs_io_top u_trs_io_top (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_cs_n       (spi_cs_n),
    .sck            (sck),
    .mosi           (mosi),
    .miso           (miso),
    .led            (led),
    .esp_status     (esp_status),
    .screen_color   (screen_color),
    .key_pressed    (key_pressed),
    .spi_error      (spi_error)
  );

  always #5 clk = ~clk;  // 10 ns period

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("** Error at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
    end
  endtask

  task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("** Error at %0t ns: %s expected 0x%06h, got 0x%06h", $time, name, exp, act);
    end
  endtask

  task automatic check_led(input string name, input led_t exp, input led_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("** Error at %0t ns: %s expected rgb %03b, got %03b", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("** Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic note_timeout(input string what);
    timeout_count++;
    $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
  endtask

  // the response must be loaded before the master clocks the dummy byte
  task automatic wait_resp_busy();
    int n;
    n = 0;
    @(negedge clk);
    while (u_trs_io_top.resp_busy !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (u_trs_io_top.resp_busy !== 1'b1)
      note_timeout("response load");
  endtask

  // deselect seen inside and no response in flight
  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    while ((u_trs_io_top.cs_active || u_trs_io_top.resp_busy) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (u_trs_io_top.cs_active || u_trs_io_top.resp_busy)
      note_timeout("return to idle after chip select");
  endtask

  // mode 0 byte, mosi set while sck low, miso read just before each rise
  task automatic spi_xfer(input byte_t tx, output byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      @(posedge clk);
      sck  <= 1'b0;
      mosi <= tx[i];
      repeat (PHASE_CLKS - 1) @(posedge clk);
      @(negedge clk);
      rx[i] = miso;
      @(posedge clk);
      sck <= 1'b1;
      repeat (PHASE_CLKS - 1) @(posedge clk);
    end
    @(posedge clk);
    sck <= 1'b0;  // last falling edge
    repeat (PHASE_CLKS - 1) @(posedge clk);
  endtask

  task automatic spi_send_byte(input byte_t tx);
    byte_t ignored;
    spi_xfer(tx, ignored);
  endtask

  task automatic spi_read_byte(output byte_t rx);
    spi_xfer(8'hFF, rx);  // dummy byte, an unknown opcode unless dropped
  endtask

  task automatic frame_open();
    @(posedge clk);
    spi_cs_n <= 1'b0;
    repeat (PHASE_CLKS) @(posedge clk);
  endtask

  task automatic frame_close();
    @(posedge clk);
    spi_cs_n <= 1'b1;
    wait_idle();
  endtask

  // opcode plus the first n bytes of prm, p0 in the top byte
  task automatic send_message(input byte_t op, input logic [23:0] prm, input int n);
    frame_open();
    spi_send_byte(op);
    for (int i = 0; i < n; i++)
      spi_send_byte(prm[23 - 8*i -: 8]);
    frame_close();
  endtask

  task automatic query(input byte_t op, output byte_t resp);
    frame_open();
    spi_send_byte(op);
    wait_resp_busy();
    spi_read_byte(resp);
    frame_close();
  endtask

  task automatic update_model(input byte_t op, input logic [23:0] prm);
    case (op)
      OP_SET_LED:          exp_led = '{red: prm[16], green: prm[17], blue: prm[18]};
      OP_SET_ESP_STATUS:   exp_status = prm[23:16];
      OP_SEND_KEYB:        exp_matrix[prm[18:16]] = prm[15:8];  // row index uses 3 bits
      OP_SET_SCREEN_COLOR: exp_color = prm;
      default: ;
    endcase
  endtask

  function automatic logic model_key_pressed();
    logic hit;
    hit = 1'b0;
    for (int r = 0; r < KEYB_ROWS; r++)
      hit = hit | (|exp_matrix[r]);
    return hit;
  endfunction

  function automatic int param_count(input byte_t op);
    case (op)
      OP_SEND_KEYB:        return 2;
      OP_SET_SCREEN_COLOR: return 3;
      default:             return 1;
    endcase
  endfunction

  function automatic logic kept_opcode(input byte_t op);
    return op inside {OP_GET_COOKIE, OP_GET_VERSION, OP_SET_SCREEN_COLOR,
                      OP_SEND_KEYB, OP_SET_LED, OP_SET_ESP_STATUS};
  endfunction

  function automatic byte_t pick_param_op();
    case ($urandom % 4)
      0:       return OP_SET_LED;
      1:       return OP_SET_ESP_STATUS;
      2:       return OP_SEND_KEYB;
      default: return OP_SET_SCREEN_COLOR;
    endcase
  endfunction

  task automatic check_outputs();
    @(negedge clk);  // away from the update edge
    check_led("led", exp_led, led);
    check_byte("esp_status", exp_status, esp_status);
    check_rgb("screen_color", exp_color, screen_color);
    check_bit("key_pressed", model_key_pressed(), key_pressed);
    check_bit("spi_error", exp_error, spi_error);
  endtask

  initial begin
    byte_t       op;
    byte_t       resp;
    byte_t       val;
    logic [23:0] prm;
    int          cookies;
    int          versions;
    void'($urandom(91));
    clk            = 1'b0;
    cass_out_sel_n = 1'b0;
    spi_cs_n       = 1'b1;  // deselected
    sck            = 1'b0;
    mosi           = 1'b0;
    err_count      = 0;
    timeout_count  = 0;
    check_count    = 0;
    exp_led        = '0;
    exp_status     = '0;
    exp_color      = 24'hFFFFFF;  // white
    exp_matrix     = '{default: '0};
    exp_error      = 1'b0;
    repeat (3) @(posedge clk);
    cass_out_sel_n <= 1'b1;
    repeat (2) @(posedge clk);
    check_outputs();

    // cookie and version, 10 of each, shuffled
    cookies  = 10;
    versions = 10;
    while (cookies + versions > 0) begin
      if (versions == 0 || (cookies > 0 && $urandom % 2 == 0)) begin
        query(OP_GET_COOKIE, resp);
        check_byte("miso cookie", EXP_COOKIE, resp);
        cookies--;
      end else begin
        query(OP_GET_VERSION, resp);
        check_byte("miso version", EXP_VERSION, resp);
        versions--;
      end
      check_outputs();
    end

    // led, status and color writes
    for (int i = 0; i < 60; i++) begin
      case ($urandom % 3)
        0:       op = OP_SET_LED;
        1:       op = OP_SET_ESP_STATUS;
        default: op = OP_SET_SCREEN_COLOR;
      endcase
      prm = 24'($urandom);
      send_message(op, prm, param_count(op));
      update_model(op, prm);
      check_outputs();
    end

    // keyboard rows, a third of them written back to zero
    for (int i = 0; i < 40; i++) begin
      val = ($urandom % 3 == 0) ? 8'h00 : byte_t'($urandom);
      prm = {byte_t'($urandom), val, 8'h00};
      send_message(OP_SEND_KEYB, prm, 2);
      update_model(OP_SEND_KEYB, prm);
      check_outputs();
    end
    for (int r = 0; r < KEYB_ROWS; r++) begin
      prm = {5'($urandom), 3'(r), 16'h0000};
      send_message(OP_SEND_KEYB, prm, 2);
      update_model(OP_SEND_KEYB, prm);
      check_outputs();
    end
    check_bit("key_pressed after clear", 1'b0, key_pressed);

    // unknown opcode, error sticks, decoding goes on
    op = byte_t'($urandom);
    while (kept_opcode(op))
      op = byte_t'($urandom);
    send_message(op, 24'h000000, 0);
    exp_error = 1'b1;
    check_outputs();
    query(OP_GET_COOKIE, resp);
    check_byte("miso cookie after error", EXP_COOKIE, resp);
    check_outputs();

    // messages cut short by cs, then sent in full
    for (int i = 0; i < 8; i++) begin
      op  = pick_param_op();
      prm = 24'($urandom);
      send_message(op, prm, int'($urandom % param_count(op)));
      check_outputs();
      prm = 24'($urandom);
      send_message(op, prm, param_count(op));
      update_model(op, prm);
      check_outputs();
    end

    finish_run();
  end

endmodule

`default_nettype wire

/* verification/trs_io_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module trs_io_assertions
  import trs_io_pkg::*;
(
  input logic        clk,
  input logic        cass_out_sel_n,
  input logic        spi_cs_n,
  input logic        miso,
  input logic        spi_error,
  input cmd_action_t action
);

  // cs reaches the tx side 2 clk late, busy clears one clk after that
  a_miso_idle: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    (spi_cs_n && $past(spi_cs_n) && $past(spi_cs_n, 2) && $past(spi_cs_n, 3)) |-> !miso)
    else $error("miso high while chip select is inactive");

  a_error_sticky: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    spi_error |=> spi_error)
    else $error("spi_error dropped without a reset");

  a_action_pulse: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    action.valid |=> !action.valid)  // one clock per command
    else $error("action.valid held for two cycles");

endmodule

bind trs_io_top trs_io_assertions u_trs_io_assertions (
  .clk            (clk),
  .cass_out_sel_n (cass_out_sel_n),
  .spi_cs_n       (spi_cs_n),
  .miso           (miso),
  .spi_error      (spi_error),
  .action         (action)
);

`default_nettype wire

/* src/trs_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module trs_io_top
  import trs_io_pkg::*;
(
  input  logic  clk,
  input  logic  cass_out_sel_n,
  input  logic  spi_cs_n,
  input  logic  sck,
  input  logic  mosi,
  output logic  miso,
  output led_t  led,
  output byte_t esp_status,
  output rgb_t  screen_color,
  output logic  key_pressed,
  output logic  spi_error
);

  byte_t       rx_byte;
  logic        rx_valid;
  logic        cs_active;
  logic        sck_fall;
  cmd_action_t action;
  byte_t       resp_byte;
  logic        resp_load;
  logic        resp_busy;
  logic        bad_opcode;

  // mosi side, bytes in
  spi_byte_rx u_spi_byte_rx (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_cs_n       (spi_cs_n),
    .sck            (sck),
    .mosi           (mosi),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .cs_active      (cs_active),
    .sck_fall       (sck_fall)
  );

  cmd_decoder u_cmd_decoder (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_active      (cs_active),
    .rx_valid       (rx_valid),
    .resp_busy      (resp_busy),
    .rx_byte        (rx_byte),
    .action         (action),
    .resp_byte      (resp_byte),
    .resp_load      (resp_load),
    .bad_opcode     (bad_opcode)
  );

  trs_io_regs u_trs_io_regs (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .bad_opcode     (bad_opcode),
    .action         (action),
    .led            (led),
    .esp_status     (esp_status),
    .screen_color   (screen_color),
    .key_pressed    (key_pressed),
    .spi_error      (spi_error)
  );

  // miso side, response byte out
  spi_byte_tx u_spi_byte_tx (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_active      (cs_active),
    .sck_fall       (sck_fall),
    .resp_load      (resp_load),
    .resp_byte      (resp_byte),
    .miso           (miso),
    .resp_busy      (resp_busy)
  );

endmodule

`default_nettype wire

/* src/trs_io_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module trs_io_regs
  import trs_io_pkg::*;
(
  input  logic        clk,
  input  logic        cass_out_sel_n,
  input  logic        bad_opcode,
  input  cmd_action_t action,
  output led_t        led,
  output byte_t       esp_status,
  output rgb_t        screen_color,
  output logic        key_pressed,
  output logic        spi_error
);

  byte_t     keyb_matrix [KEYB_ROWS];
  keyb_row_t row;
  logic      any_key;

  assign row = keyb_row_t'(action.p0[2:0]);  // upper bits of the index ignored

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led          <= '0;                   // all off
      esp_status   <= '0;
      screen_color <= SCREEN_COLOR_RESET;
      keyb_matrix  <= '{default: '0};
      spi_error    <= 1'b0;
    end else begin
      if (bad_opcode)
        spi_error <= 1'b1;  // sticky until reset
      if (action.valid) begin
        case (action.opcode)
          OP_SET_LED: led <= '{red: action.p0[0], green: action.p0[1], blue: action.p0[2]};
          OP_SET_ESP_STATUS:   esp_status       <= action.p0;
          OP_SEND_KEYB:        keyb_matrix[row] <= action.p1;
          OP_SET_SCREEN_COLOR: screen_color     <= {action.p0, action.p1, action.p2};
          default: ;
        endcase
      end
    end
  end

  // any bit set anywhere in the matrix
  always_comb begin
    any_key = 1'b0;
    for (int i = 0; i < KEYB_ROWS; i++)
      any_key = any_key | (|keyb_matrix[i]);
  end

  assign key_pressed = any_key;

endmodule

`default_nettype wire

/* src/cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
  import trs_io_pkg::*;
(
  input  logic        clk,
  input  logic        cass_out_sel_n,
  input  logic        cs_active,
  input  logic        rx_valid,
  input  logic        resp_busy,
  input  byte_t       rx_byte,
  output cmd_action_t action,
  output byte_t       resp_byte,
  output logic        resp_load,
  output logic        bad_opcode
);

  dec_state_t state;
  param_cnt_t remain;     // parameter bytes still expected
  param_cnt_t idx;        // slot for the next parameter
  logic       byte_ok;
  logic       act_valid;
  byte_t      act_opcode;
  byte_t      act_p0;
  byte_t      act_p1;
  byte_t      act_p2;
  byte_t      resp_q;

  // response byte in flight, so the master's dummy byte is dropped
  assign byte_ok = rx_valid && !resp_busy;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state      <= dec_idle;
      remain     <= '0;
      idx        <= '0;
      act_valid  <= 1'b0;
      resp_load  <= 1'b0;
      bad_opcode <= 1'b0;
    end else begin
      act_valid  <= 1'b0;   // pulses
      resp_load  <= 1'b0;
      bad_opcode <= 1'b0;
      if (!cs_active) begin
        state <= dec_idle;  // cs high frames each message
      end else if (byte_ok) begin
        case (state)
          dec_idle: begin
            idx <= '0;
            case (rx_byte)
              OP_GET_COOKIE,
              OP_GET_VERSION: resp_load <= 1'b1;  // answer right away
              OP_SET_LED,
              OP_SET_ESP_STATUS: begin
                remain <= 2'd1;
                state  <= dec_read_params;
              end
              OP_SEND_KEYB: begin
                remain <= 2'd2;             // row, value
                state  <= dec_read_params;
              end
              OP_SET_SCREEN_COLOR: begin
                remain <= 2'd3;             // r, g, b
                state  <= dec_read_params;
              end
              default: bad_opcode <= 1'b1;
            endcase
          end
          dec_read_params: begin
            idx <= idx + 2'd1;
            if (remain == 2'd1) begin
              act_valid <= 1'b1;            // last param is in
              state     <= dec_idle;
            end else begin
              remain <= remain - 2'd1;
            end
          end
          default: state <= dec_idle;
        endcase
      end
    end
  end

  // opcode, params and response byte
  always_ff @(posedge clk) begin
    if (cs_active && byte_ok) begin
      if (state == dec_idle) begin
        act_opcode <= rx_byte;
        resp_q     <= (rx_byte == OP_GET_VERSION) ? {VERSION_MAJOR, VERSION_MINOR} : COOKIE;
      end else begin
        case (idx)
          2'd0:    act_p0 <= rx_byte;
          2'd1:    act_p1 <= rx_byte;
          default: act_p2 <= rx_byte;
        endcase
      end
    end
  end

  assign action = '{valid: act_valid, opcode: act_opcode, p0: act_p0, p1: act_p1, p2: act_p2};
  assign resp_byte = resp_q;

endmodule

`default_nettype wire

/* spi/spi_byte_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_byte_tx
  import trs_io_pkg::*;
(
  input  logic  clk,
  input  logic  cass_out_sel_n,
  input  logic  cs_active,
  input  logic  sck_fall,
  input  logic  resp_load,
  input  byte_t resp_byte,
  output logic  miso,
  output logic  resp_busy
);

  byte_t      shift_q;
  logic [2:0] bit_cnt;   // bits already shifted out
  logic       busy_q;
  logic       shown_q;   // msb is on the line
  logic       shift_en;

  // first falling edge only presents the msb, the later ones shift
  assign shift_en = cs_active && busy_q && shown_q && sck_fall && (bit_cnt != 3'd7);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt <= '0;
      busy_q  <= 1'b0;
      shown_q <= 1'b0;
    end else if (!cs_active) begin
      busy_q  <= 1'b0;  // frame ended, drop the transfer
      shown_q <= 1'b0;
    end else if (resp_load) begin
      busy_q  <= 1'b1;
      shown_q <= 1'b0;
      bit_cnt <= '0;
    end else if (busy_q && sck_fall) begin
      if (!shown_q) begin
        shown_q <= 1'b1;
      end else if (bit_cnt == 3'd7) begin
        busy_q  <= 1'b0;  // falling edge after the lsb was read
        shown_q <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (resp_load)
      shift_q <= resp_byte;
    else if (shift_en)
      shift_q <= {shift_q[6:0], 1'b0};
  end

  assign miso      = busy_q & shown_q & shift_q[7];  // low outside a transfer
  assign resp_busy = busy_q;

endmodule

`default_nettype wire

/* spi/spi_byte_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_byte_rx
  import trs_io_pkg::*;
(
  input  logic  clk,
  input  logic  cass_out_sel_n,
  input  logic  spi_cs_n,
  input  logic  sck,
  input  logic  mosi,
  output byte_t rx_byte,
  output logic  rx_valid,
  output logic  cs_active,
  output logic  sck_fall
);

  logic [2:0] sck_q;    // 2 sync stages + 1 history for edges
  logic [1:0] cs_q;
  logic [1:0] mosi_q;   // same depth as sck so data lines up
  logic [2:0] bit_cnt;
  logic       sck_rise;
  byte_t      shift_q;

  // pin synchronizers
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_q  <= '0;
      cs_q   <= 2'b11;  // deselected
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[0], spi_cs_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign cs_active = ~cs_q[1];
  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      // 8th rising edge completes the byte
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7);
      if (!cs_active)
        bit_cnt <= '0;       // realign on every frame
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  // msb first, sampled on sck rising edges
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      shift_q <= {shift_q[6:0], mosi_q[1]};
  end

  assign rx_byte = shift_q;  // complete while rx_valid is high

endmodule

`default_nettype wire

/* common/trs_io_pkg.sv */
`default_nettype none

package trs_io_pkg;

  localparam int KEYB_ROWS = 8;  // rows of the keyboard matrix

  typedef logic [7:0]                   byte_t;       // one SPI or data byte
  typedef logic [23:0]                  rgb_t;        // red in the top byte
  typedef logic [$clog2(KEYB_ROWS)-1:0] keyb_row_t;   // matrix row index
  typedef logic [1:0]                   param_cnt_t;  // param bytes still to come

  localparam byte_t      COOKIE             = 8'hAF;
  localparam logic [2:0] VERSION_MAJOR      = 3'd0;
  localparam logic [4:0] VERSION_MINOR      = 5'd3;
  localparam rgb_t       SCREEN_COLOR_RESET = 24'hFFFFFF;  // white

  // opcodes kept from the co-processor command set
  localparam byte_t OP_GET_COOKIE       = 8'd0;
  localparam byte_t OP_GET_VERSION      = 8'd15;
  localparam byte_t OP_SET_SCREEN_COLOR = 8'd17;
  localparam byte_t OP_SEND_KEYB        = 8'd19;
  localparam byte_t OP_SET_LED          = 8'd26;
  localparam byte_t OP_SET_ESP_STATUS   = 8'd32;

  typedef enum logic {
    dec_idle,         // waiting for an opcode
    dec_read_params   // gathering parameter bytes
  } dec_state_t;

  // one completed command, valid for a single clock
  typedef struct packed {
    logic  valid;
    byte_t opcode;
    byte_t p0;
    byte_t p1;
    byte_t p2;
  } cmd_action_t;

  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } led_t;

endpackage

`default_nettype wire
